/* design/rast_defines.svh */
// Fixed-point format and geometry counts shared by the rasterizer.
// Included by the package and by any module that sizes a vector from it.
// Coordinates are signed with RAST_RADIX fraction bits.

`ifndef RAST_DEFINES_SVH
`define RAST_DEFINES_SVH

// Bits in one coordinate or color value
`define RAST_SIGFIG 24

// Fraction bits in a coordinate
`define RAST_RADIX 10

// Vertices per triangle
`define RAST_VERTS 3

// Color channels per triangle
`define RAST_COLORS 3

// Width of the one-hot sample interval code
`define RAST_SUBSAMPLE_W 4

`endif

/* design/rast_pkg.sv */
// Types shared across the rasterizer pipeline.
// Modules import this package inside their body and use scoped names in port lists.

`include "rast_defines.svh"

package rast_pkg;

    typedef logic signed [`RAST_SIGFIG-1:0] coord_t;   // Fixed-point position
    typedef logic [`RAST_SIGFIG-1:0] chan_t;           // Unsigned color channel
    typedef logic [`RAST_SUBSAMPLE_W-1:0] subsample_t; // One-hot, 1000 is one pixel

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } color_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
        color_t  color;
    } triangle_t;

    // Sample grid bounds, inclusive on both ends
    typedef struct packed {
        coord_t x_min;
        coord_t y_min;
        coord_t x_max;
        coord_t y_max;
    } box_t;

    typedef struct packed {
        coord_t screen_x;
        coord_t screen_y;
        coord_t step;      // Sample spacing in fixed point
    } rast_cfg_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } sample_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        color_t color;
    } fragment_t;

    typedef enum logic {
        IDLE,
        SCAN
    } iter_state_t;

endpackage

/* design/rast_config.sv */
// Control registers for screen size and sample interval.
// New values are taken only on edges where no triangle is offered or in flight.
// The one-hot sample code becomes a power-of-two fixed-point step.

`timescale 1ns/1ns
`include "rast_defines.svh"

module rast_config (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rast_pkg::sample_t    screen,
    input  rast_pkg::subsample_t subsample,
    input  logic                 valid_tri,
    input  logic                 halt,
    output rast_pkg::rast_cfg_t  cfg
);
    import rast_pkg::*;

    logic   idle;
    logic   sub_onehot;
    coord_t step_next;

    assign idle = !halt && !valid_tri;

    // Exactly one bit set
    assign sub_onehot = (subsample != '0) && ((subsample & (subsample - 1'b1)) == '0);

    // Top bit of the code is a full pixel, each lower bit halves it
    always_comb begin
        step_next = cfg.step;   // Bad code keeps the old step
        if (sub_onehot) begin
            for (int p = 0; p < `RAST_SUBSAMPLE_W; p++) begin
                if (subsample[p]) begin
                    step_next = coord_t'(1) << (`RAST_RADIX - `RAST_SUBSAMPLE_W + 1 + p);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.screen_x <= '0;
            cfg.screen_y <= '0;
            cfg.step     <= coord_t'(1) << `RAST_RADIX;   // One sample per pixel
        end else if (idle) begin
            cfg.screen_x <= screen.x;
            cfg.screen_y <= screen.y;
            cfg.step     <= step_next;
        end
    end

    // Box and iterator both rely on a steady grid for the whole triangle
    cfg_stable_busy: assert property (@(posedge clk) disable iff (!arst_n)
        halt |=> $stable(cfg))
        else $error("cfg changed while a triangle was in flight");

endmodule

/* design/rast_bbox.sv */
// Bounding box stage of the rasterizer.
// Takes one triangle when valid_tri is high and halt is low, snaps its box to the
// sample grid and clamps it to the screen. Empty boxes and zero-area triangles
// are dropped here, so they never raise halt downstream.

`timescale 1ns/1ns
`include "rast_defines.svh"

module rast_bbox (
    input  logic                clk,
    input  logic                arst_n,
    input  rast_pkg::triangle_t tri_in,
    input  logic                valid_tri,
    input  logic                halt,
    input  rast_pkg::rast_cfg_t cfg,
    output rast_pkg::box_t      box,
    output rast_pkg::triangle_t tri_out,
    output logic                box_valid
);
    import rast_pkg::*;

    coord_t step_mask;   // Clears bits finer than the step
    coord_t lim_x;
    coord_t lim_y;
    box_t   box_raw;
    box_t   box_next;
    logic   signed [2*`RAST_SIGFIG+2:0] area;
    logic   accept;
    logic   empty;
    logic   degenerate;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign step_mask = ~(cfg.step - coord_t'(1));

    // Last grid point strictly inside the screen
    assign lim_x = (cfg.screen_x - coord_t'(1)) & step_mask;
    assign lim_y = (cfg.screen_y - coord_t'(1)) & step_mask;

    always_comb begin
        box_raw.x_min = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_raw.y_min = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
        box_raw.x_max = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_raw.y_max = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);

        // Masking rounds toward minus infinity, negatives included
        box_next.x_min = box_raw.x_min & step_mask;
        box_next.y_min = box_raw.y_min & step_mask;
        box_next.x_max = box_raw.x_max & step_mask;
        box_next.y_max = box_raw.y_max & step_mask;

        if (box_next.x_min < 0) box_next.x_min = '0;
        if (box_next.y_min < 0) box_next.y_min = '0;
        if (box_next.x_max > lim_x) box_next.x_max = lim_x;
        if (box_next.y_max > lim_y) box_next.y_max = lim_y;
    end

    // Twice the signed area, wide enough to stay exact
    always_comb begin
        area = (tri_in.v1.x - tri_in.v0.x) * (tri_in.v2.y - tri_in.v0.y)
             - (tri_in.v2.x - tri_in.v0.x) * (tri_in.v1.y - tri_in.v0.y);
    end

    assign degenerate = (area == 0);
    assign empty      = (box_next.x_min > box_next.x_max) || (box_next.y_min > box_next.y_max);
    assign accept     = valid_tri && !halt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            box_valid <= 1'b0;
        end else begin
            box_valid <= accept && !empty && !degenerate;   // Single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            box     <= box_next;
            tri_out <= tri_in;
        end
    end

    box_ordered: assert property (@(posedge clk) disable iff (!arst_n)
        box_valid |-> (box.x_min <= box.x_max) && (box.y_min <= box.y_max))
        else $error("box_valid with an inverted box");

endmodule

/* design/rast_iterator.sv */
// Sample iterator of the rasterizer.
// Loads a box on the box_valid cycle and walks it in row-major order,
// one sample per clock, x fastest. halt holds the triangle source off from
// the box_valid cycle through the cycle of the last sample.

`timescale 1ns/1ns

module rast_iterator (
    input  logic                clk,
    input  logic                arst_n,
    input  rast_pkg::box_t      box,
    input  rast_pkg::triangle_t tri_in,
    input  logic                box_valid,
    input  rast_pkg::rast_cfg_t cfg,
    output logic                halt,
    output rast_pkg::sample_t   sample,
    output rast_pkg::triangle_t tri_out,
    output logic                sample_valid
);
    import rast_pkg::*;

    iter_state_t state;
    box_t        box_r;     // Box of the triangle being scanned
    logic        row_end;
    logic        last;

    assign halt = box_valid || (state == SCAN);

    assign row_end = (sample.x >= box_r.x_max);
    assign last    = row_end && (sample.y >= box_r.y_max);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            sample_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (box_valid) begin
                        state        <= SCAN;
                        sample_valid <= 1'b1;
                    end
                end
                SCAN: begin
                    if (last) begin   // Final sample is on the output now
                        state        <= IDLE;
                        sample_valid <= 1'b0;
                    end
                end
                default: begin
                    state        <= IDLE;
                    sample_valid <= 1'b0;
                end
            endcase
        end
    end

    // Position and triangle registers
    always_ff @(posedge clk) begin
        if ((state == IDLE) && box_valid) begin
            box_r    <= box;
            tri_out  <= tri_in;
            sample.x <= box.x_min;   // Start at the top-left grid point
            sample.y <= box.y_min;
        end else if ((state == SCAN) && !last) begin
            if (row_end) begin
                sample.x <= box_r.x_min;
                sample.y <= sample.y + cfg.step;
            end else begin
                sample.x <= sample.x + cfg.step;
            end
        end
    end

    // Guards the state and valid registers from drifting apart
    no_sample_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (state == IDLE) |-> !sample_valid)
        else $error("sample_valid high while iterator idle");

endmodule

/* design/rast_sample_test.sv */
// Inside test for one sample against one triangle, two clocks deep.
// Stage one moves the vertices so the sample sits at the origin.
// Stage two evaluates the three edge functions and emits a fragment on a hit.

`timescale 1ns/1ns
`include "rast_defines.svh"

module rast_sample_test (
    input  logic                clk,
    input  logic                arst_n,
    input  rast_pkg::sample_t   sample,
    input  rast_pkg::triangle_t tri_in,
    input  logic                sample_valid,
    output rast_pkg::fragment_t frag,
    output logic                hit_valid
);
    import rast_pkg::*;

    vertex_t verts [`RAST_VERTS];
    coord_t  vx_s1 [`RAST_VERTS];   // Vertices relative to the sample
    coord_t  vy_s1 [`RAST_VERTS];
    sample_t sample_s1;
    coord_t  z_s1;
    logic    [`RAST_COLORS-1:0][`RAST_SIGFIG-1:0] color_s1;
    logic    valid_s1;
    logic    signed [2*`RAST_SIGFIG:0] edge_val [`RAST_VERTS];
    logic    covered;

    always_comb begin
        verts[0] = tri_in.v0;
        verts[1] = tri_in.v1;
        verts[2] = tri_in.v2;
    end

    // Stage one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= sample_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            for (int i = 0; i < `RAST_VERTS; i++) begin
                vx_s1[i] <= verts[i].x - sample.x;
                vy_s1[i] <= verts[i].y - sample.y;
            end
            sample_s1 <= sample;
            z_s1      <= tri_in.v0.z;     // Flat z from the first vertex
            color_s1  <= tri_in.color;
        end
    end

    // Stage two, edge i runs from vertex i to vertex i+1
    always_comb begin
        for (int i = 0; i < `RAST_VERTS; i++) begin
            edge_val[i] = vx_s1[i] * vy_s1[(i + 1) % `RAST_VERTS]
                        - vx_s1[(i + 1) % `RAST_VERTS] * vy_s1[i];
        end
    end

    // Clockwise winding, edge 1 strict so shared edges hit only once
    assign covered = (edge_val[0] <= 0) && (edge_val[1] < 0) && (edge_val[2] <= 0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= valid_s1 && covered;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s1) begin
            frag.x     <= sample_s1.x;
            frag.y     <= sample_s1.y;
            frag.z     <= z_s1;
            frag.color <= color_t'(color_s1);
        end
    end

endmodule

/* design/rast_top.sv */
// Top level of the triangle rasterizer.
// Triangles enter on valid_tri and are held off by halt while one is in flight.
// Covered samples leave as fragments on hit_valid, with no output stall.

`timescale 1ns/1ns

module rast_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rast_pkg::triangle_t  tri_in,
    input  logic                 valid_tri,
    input  rast_pkg::sample_t    screen,
    input  rast_pkg::subsample_t subsample,
    output logic                 halt,
    output rast_pkg::fragment_t  frag,
    output logic                 hit_valid
);
    import rast_pkg::*;

    rast_cfg_t cfg;
    box_t      box;
    triangle_t tri_box;     // Triangle beside its box
    triangle_t tri_iter;    // Triangle beside the current sample
    logic      box_valid;
    sample_t   sample;
    logic      sample_valid;

    rast_config u_config (
        .clk       (clk),
        .arst_n    (arst_n),
        .screen    (screen),
        .subsample (subsample),
        .valid_tri (valid_tri),
        .halt      (halt),
        .cfg       (cfg)
    );

    rast_bbox u_bbox (
        .clk       (clk),
        .arst_n    (arst_n),
        .tri_in    (tri_in),
        .valid_tri (valid_tri),
        .halt      (halt),
        .cfg       (cfg),
        .box       (box),
        .tri_out   (tri_box),
        .box_valid (box_valid)
    );

    rast_iterator u_iterator (
        .clk          (clk),
        .arst_n       (arst_n),
        .box          (box),
        .tri_in       (tri_box),
        .box_valid    (box_valid),
        .cfg          (cfg),
        .halt         (halt),
        .sample       (sample),
        .tri_out      (tri_iter),
        .sample_valid (sample_valid)
    );

    rast_sample_test u_sample_test (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample       (sample),
        .tri_in       (tri_iter),
        .sample_valid (sample_valid),
        .frag         (frag),
        .hit_valid    (hit_valid)
    );

endmodule

/* testbench/rast_tb_tasks.svh */
// Driver, wait, compare and test tasks for the rasterizer testbench.
// Included inside rast_tb, so they work on its signals and model state.
// Coordinates given to make_tri are in sixteenths of a pixel.

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_frag(input fragment_t got, input fragment_t exp, input int index);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t ns: frag[%0d] got %h expected %h",
                                     $time, index, got, exp));
        end
    endtask

    task automatic compare_halt(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t ns: halt got %b expected %b",
                                     $time, got, exp));
        end
    endtask

    function automatic coord_t fx(input int n);
        return coord_t'(n <<< (`RAST_RADIX - 4));
    endfunction

    // Random z and color with the corners put in clockwise order
    function automatic triangle_t make_tri(input int x0, input int y0, input int x1,
                                           input int y1, input int x2, input int y2);
        triangle_t t;
        vertex_t   v;
        t.v0.x = fx(x0);
        t.v0.y = fx(y0);
        t.v0.z = coord_t'($urandom);
        t.v1.x = fx(x1);
        t.v1.y = fx(y1);
        t.v1.z = coord_t'($urandom);
        t.v2.x = fx(x2);
        t.v2.y = fx(y2);
        t.v2.z = coord_t'($urandom);
        t.color.r = chan_t'($urandom);
        t.color.g = chan_t'($urandom);
        t.color.b = chan_t'($urandom);
        if (x0 * y1 - x1 * y0 + x1 * y2 - x2 * y1 + x2 * y0 - x0 * y2 > 0) begin
            v    = t.v1;
            t.v1 = t.v2;
            t.v2 = v;
        end
        return t;
    endfunction

    task automatic wait_halt_low(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (halt) begin
            n++;
            if (n > max_cycles) begin
                report_failure($sformatf("halt stayed high for more than %0d cycles",
                                         max_cycles));
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_config(input int screen_px, input subsample_t code);
        @(posedge clk);
        screen.x  <= fx(screen_px <<< 4);
        screen.y  <= fx(screen_px <<< 4);
        subsample <= code;
    endtask

    task automatic set_config(input int screen_px, input subsample_t code);
        drive_config(screen_px, code);
        repeat (2) @(posedge clk);   // Idle edges latch it
        model_config(screen_px, code);
    endtask

    // One triangle for a single accept edge once the pipe is idle
    task automatic send_triangle(input triangle_t t);
        wait_halt_low(5000);
        @(posedge clk);
        tri_in    <= t;
        valid_tri <= 1'b1;
        @(posedge clk);
        valid_tri <= 1'b0;
    endtask

    task automatic check_frags();
        if (got_q.size() != exp_q.size()) begin
            report_failure($sformatf("DUT sent %0d fragments where the model expects %0d",
                                     got_q.size(), exp_q.size()));
        end
        foreach (got_q[i]) begin
            if (got_q[i].x < 0 || longint'(got_q[i].x) >= cfg_screen_x ||
                got_q[i].y < 0 || longint'(got_q[i].y) >= cfg_screen_y) begin
                report_failure($sformatf("fragment %0d lies outside the screen", i));
            end
            compare_frag(got_q[i], exp_q[i], i);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_triangle();
        wait_halt_low(5000);
        repeat (3) @(negedge clk);   // Two sample-test stages past the last sample
        check_frags();
    endtask

    task automatic run_triangle(input triangle_t t);
        int n_samples;
        n_samples = model_triangle(t);
        send_triangle(t);
        @(negedge clk);
        compare_halt(halt, n_samples > 0);    // box_valid cycle
        repeat (n_samples) begin              // One sample per cycle
            @(negedge clk);
            compare_halt(halt, 1'b1);
        end
        @(negedge clk);
        compare_halt(halt, 1'b0);             // Drops after the last sample
        finish_triangle();
    endtask

    task automatic test_one_pixel();
        set_config(16, 4'b1000);
        run_triangle(small_tri);
    endtask

    task automatic test_quarter_pixel();
        set_config(16, 4'b0010);
        run_triangle(small_tri);
    endtask

    task automatic test_partly_off();
        set_config(16, 4'b1000);
        run_triangle(make_tri(-48, 64, 96, 320, 304, -32));
        set_config(16, 4'b0100);
        run_triangle(make_tri(-48, 64, 96, 320, 304, -32));
    endtask

    task automatic test_off_screen();
        set_config(16, 4'b1000);
        run_triangle(make_tri(320, 320, 400, 330, 360, 400));
        run_triangle(make_tri(32, 32, 64, 64, 96, 96));   // Collinear
        repeat (5) begin
            @(negedge clk);
            compare_halt(halt, 1'b0);
        end
    endtask

    // valid_tri stays high and the DUT picks each triangle up when halt drops
    task automatic test_back_to_back();
        int r[6];
        int idx;
        int guard;
        set_config(16, 4'b1000);
        tri_q.delete();
        tri_q.push_back(small_tri);
        tri_q.push_back(make_tri(320, 320, 400, 330, 360, 400));
        for (int k = 0; k < 4; k++) begin
            foreach (r[j]) r[j] = int'($urandom_range(255, 0));
            tri_q.push_back(make_tri(r[0], r[1], r[2], r[3], r[4], r[5]));
        end
        tri_q.push_back(small_tri);
        idx   = 0;
        guard = 0;
        @(posedge clk);
        tri_in    <= tri_q[0];
        valid_tri <= 1'b1;
        while (idx < tri_q.size()) begin
            @(negedge clk);
            guard++;
            if (guard > 20000) begin
                report_failure("back-to-back stream did not drain in time");
            end
            if (!halt) begin
                void'(model_triangle(tri_q[idx]));
                idx++;
                @(posedge clk);      // Accept edge
                if (idx < tri_q.size()) begin
                    tri_in <= tri_q[idx];
                end else begin
                    valid_tri <= 1'b0;
                end
            end
        end
        finish_triangle();
    endtask

    task automatic test_config_busy();
        int n_samples;
        set_config(16, 4'b1000);
        n_samples = model_triangle(small_tri);
        send_triangle(small_tri);
        @(negedge clk);
        compare_halt(halt, n_samples > 0);
        drive_config(8, 4'b0010);    // Lands mid-scan
        @(negedge clk);
        compare_halt(halt, 1'b1);
        finish_triangle();
        set_config(8, 4'b0010);      // Now idle so it sticks
        run_triangle(small_tri);
        set_config(16, 4'b0110);     // Two bits set so the step stays a quarter pixel
        run_triangle(small_tri);
    endtask

/* testbench/rast_tb.sv */
// Testbench for the triangle rasterizer.
// Runs directed triangle tests through rast_top and checks every fragment
// against a software model of the snap, clamp, scan order and edge rules.
// Driver, wait and compare tasks come from rast_tb_tasks.svh.

`timescale 1ns/1ns
`include "rast_defines.svh"

module rast_tb;
    import rast_pkg::*;

    logic       clk;
    logic       arst_n;
    triangle_t  tri_in;
    logic       valid_tri;
    sample_t    screen;
    subsample_t subsample;
    logic       halt;
    fragment_t  frag;
    logic       hit_valid;

    fragment_t  exp_q[$];     // Model fragments in scan order
    fragment_t  got_q[$];     // Fragments seen on the DUT output
    triangle_t  tri_q[$];     // Stream for the back-to-back test
    triangle_t  small_tri;
    longint     cfg_screen_x; // Model copy of the DUT settings
    longint     cfg_screen_y;
    longint     cfg_step;

    rast_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .tri_in    (tri_in),
        .valid_tri (valid_tri),
        .screen    (screen),
        .subsample (subsample),
        .halt      (halt),
        .frag      (frag),
        .hit_valid (hit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Registered output settles before the falling edge
    always @(negedge clk) begin
        if (arst_n && hit_valid) begin
            got_q.push_back(frag);
        end
    end

    initial begin
        #20_000_000;
        report_failure("watchdog expired before the test sequence finished");
    end

    function automatic void model_config(input int screen_px, input subsample_t code);
        cfg_screen_x = longint'(screen_px) <<< `RAST_RADIX;
        cfg_screen_y = cfg_screen_x;
        if ($countones(code) == 1) begin   // Other codes keep the old step
            for (int p = 0; p < `RAST_SUBSAMPLE_W; p++) begin
                if (code[p]) begin
                    cfg_step = (longint'(1) <<< `RAST_RADIX) >>> (`RAST_SUBSAMPLE_W - 1 - p);
                end
            end
        end
    endfunction

    function automatic longint floor_step(input longint v);
        longint r;
        r = v % cfg_step;
        if (r < 0) r += cfg_step;   // Toward minus infinity
        return v - r;
    endfunction

    // Appends the fragments of one triangle to exp_q and returns its scan length
    function automatic int model_triangle(input triangle_t t);
        longint    xs[3];
        longint    ys[3];
        longint    dx[3];
        longint    dy[3];
        longint    e[3];
        longint    bx0, by0, bx1, by1;
        longint    area;
        fragment_t f;
        int        count;
        count = 0;
        xs[0] = longint'(t.v0.x);
        xs[1] = longint'(t.v1.x);
        xs[2] = longint'(t.v2.x);
        ys[0] = longint'(t.v0.y);
        ys[1] = longint'(t.v1.y);
        ys[2] = longint'(t.v2.y);
        area = (xs[1] - xs[0]) * (ys[2] - ys[0]) - (xs[2] - xs[0]) * (ys[1] - ys[0]);
        bx0 = xs[0];
        bx1 = xs[0];
        by0 = ys[0];
        by1 = ys[0];
        for (int i = 1; i < 3; i++) begin
            if (xs[i] < bx0) bx0 = xs[i];
            if (xs[i] > bx1) bx1 = xs[i];
            if (ys[i] < by0) by0 = ys[i];
            if (ys[i] > by1) by1 = ys[i];
        end
        bx0 = floor_step(bx0);
        by0 = floor_step(by0);
        bx1 = floor_step(bx1);
        by1 = floor_step(by1);
        if (bx0 < 0) bx0 = 0;
        if (by0 < 0) by0 = 0;
        if (bx1 > floor_step(cfg_screen_x - 1)) bx1 = floor_step(cfg_screen_x - 1);
        if (by1 > floor_step(cfg_screen_y - 1)) by1 = floor_step(cfg_screen_y - 1);
        if (area == 0 || bx0 > bx1 || by0 > by1) return 0;
        for (longint y = by0; y <= by1; y += cfg_step) begin
            for (longint x = bx0; x <= bx1; x += cfg_step) begin
                count++;
                for (int i = 0; i < 3; i++) begin
                    dx[i] = xs[i] - x;
                    dy[i] = ys[i] - y;
                end
                for (int i = 0; i < 3; i++) begin
                    e[i] = dx[i] * dy[(i + 1) % 3] - dx[(i + 1) % 3] * dy[i];
                end
                if (e[0] <= 0 && e[1] < 0 && e[2] <= 0) begin
                    f.x     = coord_t'(x);
                    f.y     = coord_t'(y);
                    f.z     = t.v0.z;
                    f.color = t.color;
                    exp_q.push_back(f);
                end
            end
        end
        return count;
    endfunction

    `include "rast_tb_tasks.svh"

    initial begin
        void'($urandom(32'h3c8131b8));
        tri_in    = '0;
        valid_tri = 1'b0;
        screen    = '0;
        subsample = 4'b1000;
        arst_n    = 1'b0;
        model_config(0, 4'b1000);
        small_tri = make_tri(24, 24, 40, 116, 128, 40);
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_one_pixel();
        test_quarter_pixel();
        test_partly_off();
        test_off_screen();
        test_back_to_back();
        test_config_busy();
        $display("Test OK");
        $finish;
    end

endmodule

/* project.f */
+incdir+design
+incdir+testbench
design/rast_pkg.sv
design/rast_config.sv
design/rast_bbox.sv
design/rast_iterator.sv
design/rast_sample_test.sv
design/rast_top.sv
testbench/rast_tb.sv

/* Makefile */
# Verilator simulation of the rasterizer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module rast_tb -Mdir obj_dir -o Vrast_tb

run: compile
	./obj_dir/Vrast_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
